// File: hdl/llki_pkg.sv
`default_nettype none

package llki_pkg;

  // ----------------------------------------------------------------------
  // Register port
  // ----------------------------------------------------------------------

  // Byte address width and data width of the host register port
  localparam int ADDR_W = 8;
  localparam int DATA_W = 64;

  // Word addresses of the two host-visible registers
  localparam logic [ADDR_W-1:0] CTRLSTS_ADDR  = 8'h00;
  localparam logic [ADDR_W-1:0] SENDRECV_ADDR = 8'h08;

  // Bit positions in the control/status register
  localparam int CTRLSTS_READY_FOR_KEY = 0;
  localparam int CTRLSTS_RESP_WAITING  = 1;

  // ----------------------------------------------------------------------
  // Message format
  // ----------------------------------------------------------------------

  // Header field widths
  localparam int MSG_ID_W  = 8;
  localparam int STATUS_W  = 8;
  localparam int MSG_LEN_W = 16;

  // Message IDs, requests are even and their answers odd
  localparam logic [MSG_ID_W-1:0] MID_LOAD_KEY_REQ    = 8'h00;
  localparam logic [MSG_ID_W-1:0] MID_LOAD_KEY_ACK    = 8'h01;
  localparam logic [MSG_ID_W-1:0] MID_CLEAR_KEY_REQ   = 8'h02;
  localparam logic [MSG_ID_W-1:0] MID_CLEAR_KEY_ACK   = 8'h03;
  localparam logic [MSG_ID_W-1:0] MID_KEY_STATUS_REQ  = 8'h04;
  localparam logic [MSG_ID_W-1:0] MID_KEY_STATUS_RESP = 8'h05;
  localparam logic [MSG_ID_W-1:0] MID_ERROR_RESP      = 8'hFF;

  // Status codes returned in the response header
  localparam logic [STATUS_W-1:0] ST_GOOD            = 8'h00;
  localparam logic [STATUS_W-1:0] ST_KEY_PRESENT     = 8'h01;
  localparam logic [STATUS_W-1:0] ST_KEY_NOT_PRESENT = 8'h02;
  // Error codes
  localparam logic [STATUS_W-1:0] ST_BAD_MSG_ID      = 8'h10;
  localparam logic [STATUS_W-1:0] ST_BAD_MSG_LEN     = 8'h11;
  localparam logic [STATUS_W-1:0] ST_KEY_OVERWRITE   = 8'h12;
  localparam logic [STATUS_W-1:0] ST_BAD_KEY_LEN     = 8'h13;
  localparam logic [STATUS_W-1:0] ST_LOSS_OF_SYNC    = 8'h14;

  // Header word, msg_id sits in the lowest byte
  typedef struct packed {
    logic [DATA_W-MSG_LEN_W-STATUS_W-MSG_ID_W-1:0] rsvd;
    logic [MSG_LEN_W-1:0]                          msg_len;
    logic [STATUS_W-1:0]                           status;
    logic [MSG_ID_W-1:0]                           msg_id;
  } llki_hdr_t;

  // One send/receive word
  // Header view in idle, raw key word while a load is running
  typedef union packed {
    llki_hdr_t         hdr;
    logic [DATA_W-1:0] key;
  } llki_word_u;

  // ----------------------------------------------------------------------
  // Message engine FSM
  // ----------------------------------------------------------------------
  typedef enum logic [2:0] {
    IDLE,
    MSG_CHECK,
    LOAD_KEY_WORDS,
    WAIT_COMPLETE,
    CLEAR_KEY,
    RESPONSE
  } llki_state_e;

endpackage

`default_nettype wire

// File: hdl/llki_msg_if.sv
`timescale 1ns/1ps
`default_nettype none

// Send/receive traffic between register decode and message engine
interface llki_msg_if import llki_pkg::*; ();

  // Single-cycle strobes for the send/receive register
  logic       sr_wr;
  logic       sr_rd;

  // Word written by the host
  llki_word_u sr_wdata;

  // Response word and its valid level
  llki_word_u resp_word;
  logic       resp_waiting;

  // Register side
  modport decode (
    output sr_wr, sr_rd, sr_wdata,
    input  resp_word, resp_waiting
  );

  // FSM side
  modport engine (
    input  sr_wr, sr_rd, sr_wdata,
    output resp_word, resp_waiting
  );

endinterface

`default_nettype wire

// File: hdl/llki_reg_decode.sv
`timescale 1ns/1ps
`default_nettype none

module llki_reg_decode import llki_pkg::*; (
  input  logic              clk,
  input  logic              rst,

  // Host register port
  input  logic              reg_we_i,
  input  logic              reg_re_i,
  input  logic [ADDR_W-1:0] reg_addr_i,
  input  logic [DATA_W-1:0] reg_wdata_i,
  output logic [DATA_W-1:0] reg_rdata_o,
  output logic              reg_ack_o,
  output logic              reg_err_o,

  // Key side readiness, shown in the status register
  input  logic              key_ready_i,

  // Toward the message engine
  llki_msg_if.decode        msg
);

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------
  logic              sr_sel;
  logic              cs_sel;
  logic [1:0]        ctrlsts_q;
  logic [DATA_W-1:0] rdata_d;
  logic              err_d;

  assign sr_sel = (reg_addr_i == SENDRECV_ADDR);
  assign cs_sel = (reg_addr_i == CTRLSTS_ADDR);

  // Send/receive accesses go straight to the engine in the strobe cycle
  assign msg.sr_wr    = reg_we_i && sr_sel;
  assign msg.sr_rd    = reg_re_i && sr_sel;
  // Write data is not qualified, engine only looks at it with sr_wr
  assign msg.sr_wdata = reg_wdata_i;

  // Bad address on either access, or a write to the read-only status reg
  assign err_d = (reg_we_i && !sr_sel) ||
                 (reg_re_i && !sr_sel && !cs_sel);

  // ----------------------------------------------------------------------
  // Read mux
  // ----------------------------------------------------------------------
  always_comb begin
    rdata_d = '0;
    if (reg_re_i) begin
      if (cs_sel) begin
        // Only the two live status bits, rest reads as zero
        rdata_d[1:0] = ctrlsts_q;
      end else if (sr_sel && msg.resp_waiting) begin
        rdata_d = msg.resp_word;
      end
      // Reading send/receive with nothing pending gives zero
    end
  end

  // ----------------------------------------------------------------------
  // Status register
  // ----------------------------------------------------------------------
  // Sampled every cycle, so a response shows up here one cycle late
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ctrlsts_q <= '0;
    end else begin
      ctrlsts_q[CTRLSTS_READY_FOR_KEY] <= key_ready_i;
      ctrlsts_q[CTRLSTS_RESP_WAITING]  <= msg.resp_waiting;
    end
  end

  // ----------------------------------------------------------------------
  // Access completion
  // ----------------------------------------------------------------------
  // Every strobe is answered exactly one cycle later
  // Data and error are zero outside the ack cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      reg_ack_o   <= 1'b0;
      reg_err_o   <= 1'b0;
      reg_rdata_o <= '0;
    end else begin
      reg_ack_o   <= reg_we_i || reg_re_i;
      reg_err_o   <= err_d;
      reg_rdata_o <= rdata_d;
    end
  end

endmodule

`default_nettype wire

// File: hdl/llki_msg_engine.sv
`timescale 1ns/1ps
`default_nettype none

module llki_msg_engine import llki_pkg::*; (
  input  logic              clk,
  input  logic              rst,

  // From register decode
  llki_msg_if.engine        msg,

  // Discrete key interface
  output logic [DATA_W-1:0] key_data_o,
  output logic              key_valid_o,
  input  logic              key_ready_i,
  input  logic              key_complete_i,
  output logic              clear_key_o,
  input  logic              clear_key_ack_i
);

  // FSM state
  llki_state_e          state_q;
  llki_state_e          state_d;

  // Current message, turned into the response fields later
  logic [MSG_ID_W-1:0]  msg_id_q;
  logic [STATUS_W-1:0]  status_q;
  logic [MSG_LEN_W-1:0] msg_len_q;
  logic                 resp_waiting_q;

  // Per-cycle actions decided by the next-state logic
  logic                 load_hdr;
  logic                 fwd_word;
  logic                 dec_len;
  logic                 set_resp;
  logic [MSG_ID_W-1:0]  resp_id;
  logic [STATUS_W-1:0]  resp_st;
  logic                 resp_read;
  llki_word_u           resp_word_d;

  // Host has picked up the pending response
  assign resp_read = msg.sr_rd && resp_waiting_q;

  // ----------------------------------------------------------------------
  // Next-state logic
  // ----------------------------------------------------------------------
  always_comb begin
    state_d  = state_q;
    load_hdr = 1'b0;
    fwd_word = 1'b0;
    dec_len  = 1'b0;
    set_resp = 1'b0;
    resp_id  = msg_id_q;
    resp_st  = status_q;

    case (state_q)
      // Any send/receive write here is a header
      IDLE: begin
        if (msg.sr_wr) begin
          load_hdr = 1'b1;
          state_d  = MSG_CHECK;
        end
      end

      MSG_CHECK: begin
        case (msg_id_q)
          MID_LOAD_KEY_REQ: begin
            // Header plus at least one key word
            if (msg_len_q < 2) begin
              set_resp = 1'b1;
              resp_id  = MID_ERROR_RESP;
              resp_st  = ST_BAD_MSG_LEN;
              state_d  = RESPONSE;
            end else if (key_complete_i) begin
              // Never load over a live key
              set_resp = 1'b1;
              resp_id  = MID_ERROR_RESP;
              resp_st  = ST_KEY_OVERWRITE;
              state_d  = RESPONSE;
            end else begin
              state_d  = LOAD_KEY_WORDS;
            end
          end
          MID_CLEAR_KEY_REQ: begin
            if (msg_len_q != 1) begin
              set_resp = 1'b1;
              resp_id  = MID_ERROR_RESP;
              resp_st  = ST_BAD_MSG_LEN;
              state_d  = RESPONSE;
            end else begin
              state_d  = CLEAR_KEY;
            end
          end
          MID_KEY_STATUS_REQ: begin
            set_resp = 1'b1;
            state_d  = RESPONSE;
            if (msg_len_q != 1) begin
              resp_id = MID_ERROR_RESP;
              resp_st = ST_BAD_MSG_LEN;
            end else begin
              resp_id = MID_KEY_STATUS_RESP;
              resp_st = key_complete_i ? ST_KEY_PRESENT : ST_KEY_NOT_PRESENT;
            end
          end
          default: begin
            set_resp = 1'b1;
            resp_id  = MID_ERROR_RESP;
            resp_st  = ST_BAD_MSG_ID;
            state_d  = RESPONSE;
          end
        endcase
      end

      // msg_len counts the words still owed, header included
      LOAD_KEY_WORDS: begin
        if (msg.sr_wr) begin
          if (!key_ready_i) begin
            // Key side fell out of step, drop the word
            set_resp = 1'b1;
            resp_id  = MID_ERROR_RESP;
            resp_st  = ST_LOSS_OF_SYNC;
            state_d  = RESPONSE;
          end else if (msg_len_q == 2) begin
            // Last key word
            fwd_word = 1'b1;
            set_resp = 1'b1;
            resp_id  = MID_LOAD_KEY_ACK;
            resp_st  = ST_GOOD;
            state_d  = WAIT_COMPLETE;
          end else if (key_complete_i) begin
            // Key side is full but host still sends, so key length is wrong
            set_resp = 1'b1;
            resp_id  = MID_ERROR_RESP;
            resp_st  = ST_BAD_KEY_LEN;
            state_d  = CLEAR_KEY;
          end else begin
            fwd_word = 1'b1;
            dec_len  = 1'b1;
          end
        end
      end

      WAIT_COMPLETE: begin
        if (key_complete_i) begin
          state_d = RESPONSE;
        end
      end

      CLEAR_KEY: begin
        if (clear_key_ack_i) begin
          // An error on the way in keeps its own status
          if (msg_id_q != MID_ERROR_RESP) begin
            set_resp = 1'b1;
            resp_id  = MID_CLEAR_KEY_ACK;
            resp_st  = ST_GOOD;
          end
          state_d = RESPONSE;
        end
      end

      RESPONSE: begin
        if (resp_read) begin
          state_d = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // Control registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q        <= IDLE;
      key_valid_o    <= 1'b0;
      resp_waiting_q <= 1'b0;
    end else begin
      state_q        <= state_d;
      // One pulse per forwarded word, the cycle after its write
      key_valid_o    <= fwd_word;
      // Rises on the second cycle in RESPONSE, drops right after the read
      resp_waiting_q <= (state_q == RESPONSE) && !resp_read;
    end
  end

  // ----------------------------------------------------------------------
  // Message fields and key data
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (load_hdr) begin
      msg_id_q  <= msg.sr_wdata.hdr.msg_id;
      msg_len_q <= msg.sr_wdata.hdr.msg_len;
    end
    if (dec_len) begin
      msg_len_q <= msg_len_q - 1'b1;
    end
    if (set_resp) begin
      msg_id_q <= resp_id;
      status_q <= resp_st;
    end
    // Same word, now seen as raw key material
    if (fwd_word) begin
      key_data_o <= msg.sr_wdata.key;
    end
  end

  // Held high for the whole CLEAR_KEY stay, including the ack cycle
  assign clear_key_o = (state_q == CLEAR_KEY);

  // ----------------------------------------------------------------------
  // Response word
  // ----------------------------------------------------------------------
  always_comb begin
    resp_word_d             = '0;
    // All responses are a single header word
    resp_word_d.hdr.msg_len = 1;
    resp_word_d.hdr.status  = status_q;
    resp_word_d.hdr.msg_id  = msg_id_q;
  end

  assign msg.resp_word    = resp_word_d;
  assign msg.resp_waiting = resp_waiting_q;

endmodule

`default_nettype wire

// File: hdl/llki_pp.sv
`timescale 1ns/1ps
`default_nettype none

module llki_pp import llki_pkg::*; (
  input  logic              clk,
  input  logic              rst,

  // ----------------------------------------------------------------------
  // Host register port
  // ----------------------------------------------------------------------
  input  logic              reg_we_i,
  input  logic              reg_re_i,
  input  logic [ADDR_W-1:0] reg_addr_i,
  input  logic [DATA_W-1:0] reg_wdata_i,
  output logic [DATA_W-1:0] reg_rdata_o,
  output logic              reg_ack_o,
  output logic              reg_err_o,

  // ----------------------------------------------------------------------
  // Discrete key interface
  // ----------------------------------------------------------------------
  output logic [DATA_W-1:0] key_data_o,
  output logic              key_valid_o,
  input  logic              key_ready_i,
  input  logic              key_complete_i,
  output logic              clear_key_o,
  input  logic              clear_key_ack_i
);

  // Send/receive traffic and response between the two halves
  llki_msg_if msg_if ();

  // Register side, owns the address map and the status register
  llki_reg_decode i_reg_decode (
    .clk         (clk),
    .rst         (rst),
    .reg_we_i    (reg_we_i),
    .reg_re_i    (reg_re_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_ack_o   (reg_ack_o),
    .reg_err_o   (reg_err_o),
    .key_ready_i (key_ready_i),
    .msg         (msg_if.decode)
  );

  // Protocol FSM and key-side drive
  llki_msg_engine i_msg_engine (
    .clk             (clk),
    .rst             (rst),
    .msg             (msg_if.engine),
    .key_data_o      (key_data_o),
    .key_valid_o     (key_valid_o),
    .key_ready_i     (key_ready_i),
    .key_complete_i  (key_complete_i),
    .clear_key_o     (clear_key_o),
    .clear_key_ack_i (clear_key_ack_i)
  );

endmodule

`default_nettype wire

// File: dv/llki_pp_properties.sv
`timescale 1ns/1ps
`default_nettype none

module llki_pp_properties (
  input logic clk,
  input logic rst,
  input logic reg_we_i,
  input logic reg_re_i,
  input logic reg_ack_o,
  input logic key_valid_o,
  input logic clear_key_o,
  input logic clear_key_ack_i
);

  // ---------------------------------------------------------------------
  // Register port
  // ---------------------------------------------------------------------

  // Each strobe is answered on the next cycle
  ack_after_strobe: assert property (
    @(posedge clk) disable iff (rst) (reg_we_i || reg_re_i) |=> reg_ack_o
  ) else $error("reg_ack_o missing one cycle after a strobe");

  // No acknowledge without a strobe the cycle before
  no_stray_ack: assert property (
    @(posedge clk) disable iff (rst) !(reg_we_i || reg_re_i) |=> !reg_ack_o
  ) else $error("reg_ack_o high with no strobe in the previous cycle");

  // ---------------------------------------------------------------------
  // Discrete key interface
  // ---------------------------------------------------------------------

  // Key words and clear never overlap
  valid_or_clear: assert property (
    @(posedge clk) disable iff (rst) !(key_valid_o && clear_key_o)
  ) else $error("key_valid_o and clear_key_o high together");

  // Clear stays up until the key side answers
  clear_held: assert property (
    @(posedge clk) disable iff (rst) (clear_key_o && !clear_key_ack_i) |=> clear_key_o
  ) else $error("clear_key_o dropped before clear_key_ack_i");

endmodule

`default_nettype wire

// File: dv/tb_llki_pp.sv
`timescale 1ns/1ps
`default_nettype none

module tb_llki_pp import llki_pkg::*; ();

  // Key length the key-side model takes, in words
  localparam int TB_KEY_WORDS   = 2;
  // Six tests of a few dozen accesses, about three cycles each, plus polling
  localparam int TIMEOUT_CYCLES = 3000;

  logic              clk = 1'b0;
  logic              rst;
  logic              reg_we_i;
  logic              reg_re_i;
  logic [ADDR_W-1:0] reg_addr_i;
  logic [DATA_W-1:0] reg_wdata_i;
  logic [DATA_W-1:0] reg_rdata_o;
  logic              reg_ack_o;
  logic              reg_err_o;
  logic [DATA_W-1:0] key_data_o;
  logic              key_valid_o;
  logic              key_ready_i;
  logic              key_complete_i  = 1'b0;
  logic              clear_key_o;
  logic              clear_key_ack_i = 1'b0;

  // Key-side model state
  int                key_cnt;
  int                clr_wait;
  // Monitors
  int                clear_cnt = 0;
  int                cycles    = 0;
  logic [DATA_W-1:0] key_seen[$];
  logic [31:0]       lcg_state = 32'he5b6;

  llki_pp i_llki_pp (
    .clk             (clk),
    .rst             (rst),
    .reg_we_i        (reg_we_i),
    .reg_re_i        (reg_re_i),
    .reg_addr_i      (reg_addr_i),
    .reg_wdata_i     (reg_wdata_i),
    .reg_rdata_o     (reg_rdata_o),
    .reg_ack_o       (reg_ack_o),
    .reg_err_o       (reg_err_o),
    .key_data_o      (key_data_o),
    .key_valid_o     (key_valid_o),
    .key_ready_i     (key_ready_i),
    .key_complete_i  (key_complete_i),
    .clear_key_o     (clear_key_o),
    .clear_key_ack_i (clear_key_ack_i)
  );

  bind llki_pp llki_pp_properties i_llki_pp_properties (
    .clk             (clk),
    .rst             (rst),
    .reg_we_i        (reg_we_i),
    .reg_re_i        (reg_re_i),
    .reg_ack_o       (reg_ack_o),
    .key_valid_o     (key_valid_o),
    .clear_key_o     (clear_key_o),
    .clear_key_ack_i (clear_key_ack_i)
  );

  always #50 clk = ~clk;

  // ---------------------------------------------------------------------
  // Key-side model
  // ---------------------------------------------------------------------
  always @(posedge clk or posedge rst) begin
    if (rst) begin
      key_complete_i  <= 1'b0;
      clear_key_ack_i <= 1'b0;
      key_cnt         <= 0;
      clr_wait        <= 0;
    end else begin
      clear_key_ack_i <= 1'b0;
      // Key complete once the full key has arrived
      if (key_valid_o) begin
        key_cnt <= key_cnt + 1;
        if (key_cnt + 1 >= TB_KEY_WORDS) begin
          key_complete_i <= 1'b1;
        end
      end
      // Ack two cycles into a clear, key gone with it
      if (clear_key_o && !clear_key_ack_i) begin
        if (clr_wait == 1) begin
          clear_key_ack_i <= 1'b1;
          key_complete_i  <= 1'b0;
          key_cnt         <= 0;
          clr_wait        <= 0;
        end else begin
          clr_wait <= clr_wait + 1;
        end
      end
    end
  end

  // Record forwarded key words and clear cycles
  always @(posedge clk) begin
    if (!rst && key_valid_o) begin
      key_seen.push_back(key_data_o);
    end
    if (!rst && clear_key_o) begin
      clear_cnt++;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      stop_run("Timeout, the tests did not finish within the cycle limit");
    end
  end

  // ---------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "Run stopped on the first error");
  endtask

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      stop_run($sformatf("Fail %s: expected 0x%h, actual 0x%h", name, exp, act));
    end
  endtask

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Two generator steps per 64-bit key word
  task automatic make_key_word(output logic [DATA_W-1:0] w);
    lcg_state = lcg_step(lcg_state);
    w[63:32]  = lcg_state;
    lcg_state = lcg_step(lcg_state);
    w[31:0]   = lcg_state;
  endtask

  // Every response is a single header word with length 1
  function automatic logic [DATA_W-1:0] expect_resp(input logic [7:0] id, input logic [7:0] st);
    return {32'h0, 16'h0001, st, id};
  endfunction

  task automatic wait_ack(input logic [ADDR_W-1:0] addr, input logic exp_err);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!reg_ack_o && n < 4);
    if (!reg_ack_o) begin
      stop_run($sformatf("No register acknowledge for the access at 0x%h", addr));
    end
    if (reg_err_o !== exp_err) begin
      stop_run($sformatf("Error flag was %b at 0x%h where %b was due", reg_err_o, addr,
                         exp_err));
    end
  endtask

  task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic exp_err);
    @(posedge clk);
    reg_we_i    <= 1'b1;
    reg_addr_i  <= addr;
    reg_wdata_i <= data;
    @(posedge clk);
    reg_we_i    <= 1'b0;
    wait_ack(addr, exp_err);
  endtask

  task automatic bus_read(input logic [ADDR_W-1:0] addr, input logic exp_err,
                          output logic [DATA_W-1:0] data);
    @(posedge clk);
    reg_re_i   <= 1'b1;
    reg_addr_i <= addr;
    @(posedge clk);
    reg_re_i   <= 1'b0;
    wait_ack(addr, exp_err);
    data = reg_rdata_o;
  endtask

  task automatic send_msg(input logic [7:0] id, input logic [15:0] len);
    bus_write(SENDRECV_ADDR, {32'h0, len, 8'h00, id}, 1'b0);
  endtask

  // Poll the status register until a response waits, then fetch it
  task automatic get_resp(output logic [DATA_W-1:0] word);
    logic [DATA_W-1:0] sts;
    sts = '0;
    while (!sts[CTRLSTS_RESP_WAITING]) begin
      bus_read(CTRLSTS_ADDR, 1'b0, sts);
    end
    bus_read(SENDRECV_ADDR, 1'b0, word);
  endtask

  // Header-only request and its expected response
  task automatic request(input string name, input logic [7:0] id, input logic [15:0] len,
                         input logic [7:0] exp_id, input logic [7:0] exp_st);
    logic [DATA_W-1:0] resp;
    send_msg(id, len);
    get_resp(resp);
    check(name, expect_resp(exp_id, exp_st), resp);
  endtask

  // Header plus the two words the key side expects
  task automatic load_key(input string name, input logic [DATA_W-1:0] w0,
                          input logic [DATA_W-1:0] w1);
    logic [DATA_W-1:0] resp;
    send_msg(MID_LOAD_KEY_REQ, 16'd3);
    bus_write(SENDRECV_ADDR, w0, 1'b0);
    bus_write(SENDRECV_ADDR, w1, 1'b0);
    get_resp(resp);
    check(name, expect_resp(MID_LOAD_KEY_ACK, ST_GOOD), resp);
  endtask

  // ---------------------------------------------------------------------
  // Tests
  // ---------------------------------------------------------------------
  task automatic test_key_status();
    request("status_no_key", MID_KEY_STATUS_REQ, 16'd1, MID_KEY_STATUS_RESP, ST_KEY_NOT_PRESENT);
    request("status_bad_len", MID_KEY_STATUS_REQ, 16'd3, MID_ERROR_RESP, ST_BAD_MSG_LEN);
  endtask

  task automatic test_load_key();
    logic [DATA_W-1:0] w0;
    logic [DATA_W-1:0] w1;
    int                base;
    make_key_word(w0);
    make_key_word(w1);
    base = key_seen.size();
    load_key("load_ack", w0, w1);
    // Each word once, in order
    check("load_word_count", 64'd2, 64'(key_seen.size() - base));
    check("load_word_0", w0, key_seen[base]);
    check("load_word_1", w1, key_seen[base+1]);
    request("status_key", MID_KEY_STATUS_REQ, 16'd1, MID_KEY_STATUS_RESP, ST_KEY_PRESENT);
  endtask

  task automatic test_load_errors();
    logic [DATA_W-1:0] w;
    logic [DATA_W-1:0] resp;
    int                clr_base;
    request("load_overwrite", MID_LOAD_KEY_REQ, 16'd3, MID_ERROR_RESP, ST_KEY_OVERWRITE);
    request("load_short", MID_LOAD_KEY_REQ, 16'd1, MID_ERROR_RESP, ST_BAD_MSG_LEN);
    request("clear_for_reload", MID_CLEAR_KEY_REQ, 16'd1, MID_CLEAR_KEY_ACK, ST_GOOD);
    // Header plus four words, key side is full after two so the third is refused
    clr_base = clear_cnt;
    send_msg(MID_LOAD_KEY_REQ, 16'd5);
    repeat (3) begin
      make_key_word(w);
      bus_write(SENDRECV_ADDR, w, 1'b0);
    end
    get_resp(resp);
    check("bad_key_len", expect_resp(MID_ERROR_RESP, ST_BAD_KEY_LEN), resp);
    check("bad_key_len_clear", 64'd1, 64'(clear_cnt > clr_base));
  endtask

  task automatic test_clear_key();
    logic [DATA_W-1:0] w0;
    logic [DATA_W-1:0] w1;
    int                clr_base;
    make_key_word(w0);
    make_key_word(w1);
    load_key("load_before_clear", w0, w1);
    clr_base = clear_cnt;
    request("clear_ack", MID_CLEAR_KEY_REQ, 16'd1, MID_CLEAR_KEY_ACK, ST_GOOD);
    check("clear_seen", 64'd1, 64'(clear_cnt > clr_base));
    request("status_cleared", MID_KEY_STATUS_REQ, 16'd1, MID_KEY_STATUS_RESP,
            ST_KEY_NOT_PRESENT);
  endtask

  task automatic test_bad_access();
    logic [DATA_W-1:0] rd;
    request("bad_msg_id", 8'h07, 16'd1, MID_ERROR_RESP, ST_BAD_MSG_ID);
    // Unmapped address both ways, then the read-only status register
    bus_write(8'h10, 64'h0, 1'b1);
    bus_read(8'h10, 1'b1, rd);
    check("bad_addr_rdata", 64'h0, rd);
    bus_write(CTRLSTS_ADDR, 64'h0, 1'b1);
  endtask

  task automatic test_loss_of_sync();
    logic [DATA_W-1:0] w;
    logic [DATA_W-1:0] rd;
    int                base;
    base = key_seen.size();
    send_msg(MID_LOAD_KEY_REQ, 16'd3);
    @(posedge clk);
    key_ready_i <= 1'b0;
    bus_read(CTRLSTS_ADDR, 1'b0, rd);
    check("ready_bit_low", 64'd0, 64'(rd[CTRLSTS_READY_FOR_KEY]));
    make_key_word(w);
    bus_write(SENDRECV_ADDR, w, 1'b0);
    get_resp(rd);
    check("loss_of_sync", expect_resp(MID_ERROR_RESP, ST_LOSS_OF_SYNC), rd);
    check("no_key_word", 64'd0, 64'(key_seen.size() - base));
    @(posedge clk);
    key_ready_i <= 1'b1;
    // Ready bit follows the key side back up
    bus_read(CTRLSTS_ADDR, 1'b0, rd);
    check("ready_bit_high", 64'd1, 64'(rd[CTRLSTS_READY_FOR_KEY]));
  endtask

  initial begin
    rst         = 1'b1;
    reg_we_i    = 1'b0;
    reg_re_i    = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    key_ready_i = 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    test_key_status();
    test_load_key();
    test_load_errors();
    test_clear_key();
    test_bad_access();
    test_loss_of_sync();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
hdl/llki_pkg.sv
hdl/llki_msg_if.sv
hdl/llki_reg_decode.sv
hdl/llki_msg_engine.sv
hdl/llki_pp.sv
dv/llki_pp_properties.sv
dv/tb_llki_pp.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 -Wno-fatal \
  --top-module tb_llki_pp \
  -f filelist.f \
  -o sim_tb_llki_pp
# Exit status of the simulation is the result
./obj_dir/sim_tb_llki_pp
